// ==== tb.f ====
verilog/euclid_pkg.sv
verilog/seg_fifo.sv
verilog/line_engine.sv
verilog/bezier_subdiv.sv
verilog/euclid_job_ctrl.sv
verilog/euclid_top.sv
sim/euclid_chk.sv
sim/euclid_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module euclid_tb -o euclid_sim
./obj_dir/euclid_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/euclid_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module euclid_tb;

  localparam int NUM_JOBS = 12;

  logic                    cr_intf   = 1'b0;
  logic                    rst_n     = 1'b0;
  logic                    job_start = 1'b0;
  euclid_pkg::euclid_job_t job       = '0;
  logic                    pxl_ready = 1'b0;
  logic                    busy;
  logic                    job_done;
  logic                    pxl_valid;
  euclid_pkg::pxl_wr_t     pxl;

  euclid_pkg::euclid_job_t job_tab [NUM_JOBS];
  euclid_pkg::point_t      exp_q [$];     // Pixels still owed by the DUT

  logic [31:0] lcg_state = 32'hbcf0;
  int          cycle_limit;
  int          cycle_cnt;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  euclid_top u_euclid_top
  (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .job_start (job_start),
    .job       (job),
    .pxl_ready (pxl_ready),
    .busy      (busy),
    .job_done  (job_done),
    .pxl_valid (pxl_valid),
    .pxl       (pxl)
  );

  bind euclid_top euclid_chk u_chk
  (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .busy      (busy),
    .job_done  (job_done),
    .pxl_valid (pxl_valid),
    .pxl_ready (pxl_ready),
    .pxl       (pxl)
  );

  initial
  begin
    forever #50 cr_intf = ~cr_intf;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Gateway ready, low about one cycle in four
  always @(posedge cr_intf)
  begin
    lcg_state <= lcg_next(lcg_state);
    if (!rst_n)
      pxl_ready <= 1'b0;
    else
      pxl_ready <= (lcg_state[31:30] != 2'b00);
  end

  function automatic euclid_pkg::euclid_job_t make_job(input euclid_pkg::shape_e shape,
                                                       input int x0, input int y0,
                                                       input int x1, input int y1,
                                                       input int x2, input int y2,
                                                       input int depth,
                                                       input logic [15:0] color);
    euclid_pkg::euclid_job_t j;
    j.shape   = shape;
    j.p0.x    = x0[euclid_pkg::X_W-1:0];
    j.p0.y    = y0[euclid_pkg::Y_W-1:0];
    j.p1.x    = x1[euclid_pkg::X_W-1:0];
    j.p1.y    = y1[euclid_pkg::Y_W-1:0];
    j.p2.x    = x2[euclid_pkg::X_W-1:0];
    j.p2.y    = y2[euclid_pkg::Y_W-1:0];
    j.color   = color;
    j.bzdepth = depth[euclid_pkg::DEPTH_W-1:0];
    return j;
  endfunction

  task automatic load_table();
    // Eight octants, then a single point
    job_tab[0]  = make_job(euclid_pkg::LINE, 10, 10, 20, 14, 0, 0, 0, 16'h001f);
    job_tab[1]  = make_job(euclid_pkg::LINE, 10, 10, 14, 20, 0, 0, 0, 16'h07e0);
    job_tab[2]  = make_job(euclid_pkg::LINE, 20, 10, 10, 14, 0, 0, 0, 16'hf800);
    job_tab[3]  = make_job(euclid_pkg::LINE, 14, 10, 10, 20, 0, 0, 0, 16'h1234);
    job_tab[4]  = make_job(euclid_pkg::LINE, 20, 20, 10, 16, 0, 0, 0, 16'habcd);
    job_tab[5]  = make_job(euclid_pkg::LINE, 14, 20, 10, 10, 0, 0, 0, 16'h5a5a);
    job_tab[6]  = make_job(euclid_pkg::LINE, 10, 20, 20, 16, 0, 0, 0, 16'ha5a5);
    job_tab[7]  = make_job(euclid_pkg::LINE, 10, 20, 14, 10, 0, 0, 0, 16'h0ff0);
    job_tab[8]  = make_job(euclid_pkg::LINE, 33, 33, 33, 33, 0, 0, 0, 16'hffff);
    // Bezier at depths 0, 1 and 3
    job_tab[9]  = make_job(euclid_pkg::BEZIER, 0, 0, 20, 40, 40, 0, 0, 16'h8421);
    job_tab[10] = make_job(euclid_pkg::BEZIER, 5, 100, 60, 10, 120, 90, 1, 16'h4242);
    job_tab[11] = make_job(euclid_pkg::BEZIER, 200, 10, 100, 200, 10, 50, 3, 16'hc3c3);
  endtask

  // Bresenham reference, appends p0 through p1 to the expected list
  task automatic add_line(input euclid_pkg::point_t a, input euclid_pkg::point_t b);
    int                 x;
    int                 y;
    int                 x1;
    int                 y1;
    int                 dx;
    int                 dy;
    int                 sx;
    int                 sy;
    int                 err;
    int                 e2;
    bit                 fin;
    euclid_pkg::point_t p;
    x   = int'(a.x);
    y   = int'(a.y);
    x1  = int'(b.x);
    y1  = int'(b.y);
    dx  = (x1 > x) ? x1 - x : x - x1;
    dy  = (y1 > y) ? y1 - y : y - y1;
    sx  = (x1 >= x) ? 1 : -1;
    sy  = (y1 >= y) ? 1 : -1;
    err = dx - dy;
    fin = 1'b0;
    while (!fin)
    begin
      p.x = x[euclid_pkg::X_W-1:0];
      p.y = y[euclid_pkg::Y_W-1:0];
      exp_q.push_back(p);
      if (x == x1 && y == y1)
        fin = 1'b1;
      else
      begin
        e2 = 2 * err;
        if (e2 > -dy)
        begin
          err -= dy;
          x   += sx;
        end
        if (e2 < dx)
        begin
          err += dx;
          y   += sy;
        end
      end
    end
  endtask

  function automatic euclid_pkg::point_t midpoint(input euclid_pkg::point_t a,
                                                  input euclid_pkg::point_t b);
    int                 mx;
    int                 my;
    euclid_pkg::point_t m;
    mx  = (int'(a.x) + int'(b.x)) / 2;   // Remainder dropped
    my  = (int'(a.y) + int'(b.y)) / 2;
    m.x = mx[euclid_pkg::X_W-1:0];
    m.y = my[euclid_pkg::Y_W-1:0];
    return m;
  endfunction

  task automatic build_expected(input euclid_pkg::euclid_job_t j);
    euclid_pkg::seg_t   work_q [$];
    euclid_pkg::seg_t   t;
    euclid_pkg::seg_t   c;
    euclid_pkg::point_t m0;
    euclid_pkg::point_t m1;
    euclid_pkg::point_t m2;
    exp_q.delete();
    if (j.shape == euclid_pkg::LINE)
      add_line(j.p0, j.p1);
    else
    begin
      t.p0    = j.p0;
      t.p1    = j.p1;
      t.p2    = j.p2;
      t.depth = '0;
      work_q.push_back(t);
      // Breadth-first, leaves come out left to right
      while (work_q.size() > 0)
      begin
        t = work_q.pop_front();
        if (t.depth == j.bzdepth)
        begin
          add_line(t.p0, t.p1);
          add_line(t.p1, t.p2);
        end
        else
        begin
          m0      = midpoint(t.p0, t.p1);
          m1      = midpoint(t.p1, t.p2);
          m2      = midpoint(m0, m1);
          c.depth = t.depth + 1'b1;
          c.p0    = t.p0;
          c.p1    = m0;
          c.p2    = m2;
          work_q.push_back(c);
          c.p0    = m2;
          c.p1    = m1;
          c.p2    = t.p2;
          work_q.push_back(c);
        end
      end
    end
  endtask

  task automatic run_job(input int idx);
    int                 errs_at_start;
    int                 n_exp;
    int                 n_got;
    bit                 fin;
    euclid_pkg::point_t want;
    build_expected(job_tab[idx]);
    n_exp         = exp_q.size();
    n_got         = 0;
    errs_at_start = err_cnt;

    @(posedge cr_intf);
    job       <= job_tab[idx];
    job_start <= 1'b1;
    @(posedge cr_intf);
    job_start <= 1'b0;
    @(negedge cr_intf);
    if (!busy)
    begin
      $display("CHECK FAILED at %0t: test %0d busy did not rise after job_start", $time, idx);
      err_cnt++;
    end

    fin = 1'b0;
    while (!fin)
    begin
      @(negedge cr_intf);
      if (pxl_valid && pxl_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("CHECK FAILED at %0t: test %0d extra pixel (%0d,%0d)",
                   $time, idx, pxl.pos.x, pxl.pos.y);
          err_cnt++;
        end
        else
        begin
          want = exp_q.pop_front();
          if (pxl.pos != want || pxl.color != job_tab[idx].color)
          begin
            $display("CHECK FAILED at %0t: test %0d pixel %0d want (%0d,%0d) %h got (%0d,%0d) %h",
                     $time, idx, n_got, want.x, want.y, job_tab[idx].color,
                     pxl.pos.x, pxl.pos.y, pxl.color);
            err_cnt++;
          end
        end
        n_got++;
      end
      if (job_done)
      begin
        fin = 1'b1;
        if (exp_q.size() != 0)
        begin
          $display("CHECK FAILED at %0t: test %0d job_done with %0d pixels missing",
                   $time, idx, exp_q.size());
          err_cnt++;
        end
      end
      else if (!busy)
      begin
        $display("Test %0d: busy dropped before job_done", idx);
        err_cnt++;
        fin = 1'b1;
      end
    end

    @(negedge cr_intf);
    if (busy)
    begin
      $display("CHECK FAILED at %0t: test %0d busy still high after job_done", $time, idx);
      err_cnt++;
    end

    if (err_cnt == errs_at_start)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0d %s: %0d of %0d pixels, %s", idx,
             (job_tab[idx].shape == euclid_pkg::LINE) ? "line" : "bezier",
             n_got, n_exp, (err_cnt == errs_at_start) ? "ok" : "FAILED");
  endtask

  // Watchdog
  initial
  begin
    cycle_cnt = 0;
    @(posedge cr_intf);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge cr_intf);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    int chk_errs;
    err_cnt  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    load_table();

    cycle_limit = 10;   // Reset and start-up margin
    for (int i = 0; i < NUM_JOBS; i++)
    begin
      build_expected(job_tab[i]);
      cycle_limit += exp_q.size() * 4 + 50;
    end

    repeat (2) @(posedge cr_intf);
    rst_n <= 1'b1;
    @(negedge cr_intf);
    if (busy || pxl_valid || job_done)
    begin
      $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
      err_cnt++;
    end

    for (int i = 0; i < NUM_JOBS; i++)
      run_job(i);

    chk_errs = u_euclid_top.u_chk.stall_errs + u_euclid_top.u_chk.done_errs
               + u_euclid_top.u_chk.valid_errs;
    $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion errors",
             NUM_JOBS, pass_cnt, fail_cnt, err_cnt, chk_errs);
    if (err_cnt == 0 && fail_cnt == 0 && chk_errs == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/euclid_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module euclid_chk
(
  input wire logic                cr_intf,
  input wire logic                rst_n,
  input wire logic                busy,
  input wire logic                job_done,
  input wire logic                pxl_valid,
  input wire logic                pxl_ready,
  input wire euclid_pkg::pxl_wr_t pxl
);

  int stall_errs = 0;
  int done_errs  = 0;
  int valid_errs = 0;

  // Stalled pixel must hold
  pxl_hold_a: assert property (@(posedge cr_intf) disable iff (!rst_n)
    (pxl_valid && !pxl_ready) |=> (pxl_valid && $stable(pxl)))
  else
  begin
    stall_errs++;
    $error("pixel changed or dropped while gateway stalled");
  end

  done_pulse_a: assert property (@(posedge cr_intf) disable iff (!rst_n)
    job_done |-> (busy ##1 !job_done))
  else
  begin
    done_errs++;
    $error("job_done outside busy or longer than one cycle");
  end

  valid_busy_a: assert property (@(posedge cr_intf) disable iff (!rst_n)
    pxl_valid |-> busy)
  else
  begin
    valid_errs++;
    $error("pxl_valid high while idle");
  end

endmodule

`default_nettype wire

// ==== verilog/euclid_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module euclid_top
(
  input  wire logic                    cr_intf,
  input  wire logic                    rst_n,
  input  wire logic                    job_start,
  input  wire euclid_pkg::euclid_job_t job,
  input  wire logic                    pxl_ready,
  output logic                         busy,
  output logic                         job_done,
  output logic                         pxl_valid,
  output euclid_pkg::pxl_wr_t          pxl
);

  logic                              ctrl_seg_push;
  euclid_pkg::seg_t                  ctrl_seg_wdata;
  logic                              sub_seg_push;
  euclid_pkg::seg_t                  sub_seg_wdata;
  logic                              seg_push;
  euclid_pkg::seg_t                  seg_wdata;
  logic                              seg_pop;
  euclid_pkg::seg_t                  seg_rdata;
  logic                              seg_empty;

  logic                              subdiv_start;
  logic                              subdiv_idle;
  logic                              leaf_valid;
  euclid_pkg::seg_t                  leaf_seg;
  logic                              leaf_ack;

  logic                              line_start;
  euclid_pkg::line_req_t             line_req;
  logic                              line_busy;
  logic                              line_done;

  // Controller pushes only in START while the subdivider is idle
  assign seg_push  = ctrl_seg_push | sub_seg_push;
  assign seg_wdata = ctrl_seg_push ? ctrl_seg_wdata : sub_seg_wdata;

  euclid_job_ctrl u_job_ctrl
  (
    .cr_intf      (cr_intf),
    .rst_n        (rst_n),
    .job_start    (job_start),
    .job          (job),
    .busy         (busy),
    .job_done     (job_done),
    .seg_push     (ctrl_seg_push),
    .seg_wdata    (ctrl_seg_wdata),
    .subdiv_start (subdiv_start),
    .subdiv_idle  (subdiv_idle),
    .leaf_valid   (leaf_valid),
    .leaf_seg     (leaf_seg),
    .leaf_ack     (leaf_ack),
    .line_start   (line_start),
    .line_req     (line_req),
    .line_done    (line_done),
    .line_busy    (line_busy)
  );

  bezier_subdiv u_subdiv
  (
    .cr_intf      (cr_intf),
    .rst_n        (rst_n),
    .subdiv_start (subdiv_start),
    .bzdepth      (job.bzdepth),
    .seg_rdata    (seg_rdata),
    .seg_empty    (seg_empty),
    .seg_pop      (seg_pop),
    .seg_push     (sub_seg_push),
    .seg_wdata    (sub_seg_wdata),
    .leaf_valid   (leaf_valid),
    .leaf_seg     (leaf_seg),
    .leaf_ack     (leaf_ack),
    .subdiv_idle  (subdiv_idle)
  );

  seg_fifo u_seg_fifo
  (
    .cr_intf (cr_intf),
    .rst_n   (rst_n),
    .push    (seg_push),
    .wdata   (seg_wdata),
    .pop     (seg_pop),
    .rdata   (seg_rdata),
    .empty   (seg_empty),
    .occ     ()
  );

  line_engine u_line_engine
  (
    .cr_intf    (cr_intf),
    .rst_n      (rst_n),
    .line_start (line_start),
    .line_req   (line_req),
    .color      (job.color),
    .pxl_ready  (pxl_ready),
    .pxl_valid  (pxl_valid),
    .pxl        (pxl),
    .line_busy  (line_busy),
    .line_done  (line_done)
  );

endmodule

`default_nettype wire

// ==== verilog/euclid_job_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module euclid_job_ctrl
(
  input  wire logic                    cr_intf,
  input  wire logic                    rst_n,
  input  wire logic                    job_start,
  input  wire euclid_pkg::euclid_job_t job,
  output logic                         busy,
  output logic                         job_done,
  output logic                         seg_push,
  output euclid_pkg::seg_t             seg_wdata,
  output logic                         subdiv_start,
  input  wire logic                    subdiv_idle,
  input  wire logic                    leaf_valid,
  input  wire euclid_pkg::seg_t        leaf_seg,
  output logic                         leaf_ack,
  output logic                         line_start,
  output euclid_pkg::line_req_t        line_req,
  input  wire logic                    line_done,
  input  wire logic                    line_busy
);

  euclid_pkg::ctrl_state_e state;

  logic ln_fin_c;
  logic bz_fin_c;

  assign busy = (state != euclid_pkg::CS_IDLE);

  // Line engine back in idle and no request in flight
  assign ln_fin_c = (state == euclid_pkg::CS_LINE_RUN) & ~line_busy & ~line_start;

  // Queue drained, no leaf pending, last line finished
  assign bz_fin_c = (state == euclid_pkg::CS_BZ_RUN) & subdiv_idle & ~leaf_valid & ~line_busy;

  assign job_done = ln_fin_c | bz_fin_c;

  // Seed triangle goes in at depth 0
  assign seg_push     = (state == euclid_pkg::CS_START) & (job.shape == euclid_pkg::BEZIER);
  assign subdiv_start = seg_push;

  always_comb
  begin
    seg_wdata.p0    = job.p0;
    seg_wdata.p1    = job.p1;
    seg_wdata.p2    = job.p2;
    seg_wdata.depth = '0;
  end

  assign leaf_ack = (state == euclid_pkg::CS_LEAF1) & line_done;  // Second leaf line done

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= euclid_pkg::CS_IDLE;
      line_start <= 1'b0;
    end
    else
    begin
      line_start <= 1'b0;
      case (state)
        euclid_pkg::CS_IDLE:
        begin
          if (job_start)
            state <= euclid_pkg::CS_START;
        end
        euclid_pkg::CS_START:
        begin
          if (job.shape == euclid_pkg::LINE)
          begin
            line_start <= 1'b1;
            state      <= euclid_pkg::CS_LINE_RUN;
          end
          else
            state <= euclid_pkg::CS_BZ_RUN;
        end
        euclid_pkg::CS_LINE_RUN:
        begin
          if (ln_fin_c)
            state <= euclid_pkg::CS_IDLE;
        end
        euclid_pkg::CS_BZ_RUN:
        begin
          if (bz_fin_c)
            state <= euclid_pkg::CS_IDLE;
          else if (leaf_valid)
          begin
            line_start <= 1'b1;           // p0 to p1
            state      <= euclid_pkg::CS_LEAF0;
          end
        end
        euclid_pkg::CS_LEAF0:
        begin
          if (line_done)
          begin
            line_start <= 1'b1;           // p1 to p2
            state      <= euclid_pkg::CS_LEAF1;
          end
        end
        euclid_pkg::CS_LEAF1:
        begin
          if (line_done)
            state <= euclid_pkg::CS_BZ_RUN;
        end
        default: state <= euclid_pkg::CS_IDLE;
      endcase
    end
  end

  // Line source select, only one source is ever live
  always_ff @(posedge cr_intf)
  begin
    if (state == euclid_pkg::CS_START)
    begin
      line_req.p0 <= job.p0;
      line_req.p1 <= job.p1;
    end
    else if ((state == euclid_pkg::CS_BZ_RUN) && leaf_valid)
    begin
      line_req.p0 <= leaf_seg.p0;
      line_req.p1 <= leaf_seg.p1;
    end
    else if ((state == euclid_pkg::CS_LEAF0) && line_done)
    begin
      line_req.p0 <= leaf_seg.p1;
      line_req.p1 <= leaf_seg.p2;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bezier_subdiv.sv ====
`timescale 1ns/1ps
`default_nettype none

module bezier_subdiv
(
  input  wire logic                           cr_intf,
  input  wire logic                           rst_n,
  input  wire logic                           subdiv_start,
  input  wire logic [euclid_pkg::DEPTH_W-1:0] bzdepth,
  input  wire euclid_pkg::seg_t               seg_rdata,
  input  wire logic                           seg_empty,
  output logic                                seg_pop,
  output logic                                seg_push,
  output euclid_pkg::seg_t                    seg_wdata,
  output logic                                leaf_valid,
  output euclid_pkg::seg_t                    leaf_seg,
  input  wire logic                           leaf_ack,
  output logic                                subdiv_idle
);

  euclid_pkg::subdiv_state_e state;

  euclid_pkg::seg_t   tri_q;    // Triangle being split
  euclid_pkg::point_t m0_q;
  euclid_pkg::point_t m1_q;
  euclid_pkg::point_t m2_q;

  logic [euclid_pkg::DEPTH_W-1:0] lim_c;
  logic [euclid_pkg::DEPTH_W-1:0] child_depth_c;
  logic                           is_leaf_c;

  // Floor midpoint per coordinate
  function automatic euclid_pkg::point_t mid_pt(input euclid_pkg::point_t a,
                                                input euclid_pkg::point_t b);
    logic [euclid_pkg::X_W:0] sum_x;
    logic [euclid_pkg::Y_W:0] sum_y;
    sum_x    = {1'b0, a.x} + {1'b0, b.x};
    sum_y    = {1'b0, a.y} + {1'b0, b.y};
    mid_pt.x = sum_x[euclid_pkg::X_W:1];
    mid_pt.y = sum_y[euclid_pkg::Y_W:1];
  endfunction

  // Depth request clipped to what the queue can hold
  assign lim_c         = (bzdepth > euclid_pkg::MAX_BZ_DEPTH) ? euclid_pkg::MAX_BZ_DEPTH
                                                              : bzdepth;
  assign is_leaf_c     = (tri_q.depth >= lim_c);
  assign child_depth_c = tri_q.depth + 1'b1;

  assign seg_pop     = (state == euclid_pkg::SD_FETCH) & ~seg_empty;
  assign seg_push    = (state == euclid_pkg::SD_PUSH0) | (state == euclid_pkg::SD_PUSH1);
  assign leaf_valid  = (state == euclid_pkg::SD_LEAF);
  assign leaf_seg    = tri_q;
  assign subdiv_idle = seg_empty &
                       ((state == euclid_pkg::SD_IDLE) | (state == euclid_pkg::SD_FETCH));

  always_comb
  begin
    seg_wdata.depth = child_depth_c;
    if (state == euclid_pkg::SD_PUSH1)
    begin
      seg_wdata.p0 = m2_q;          // Right half
      seg_wdata.p1 = m1_q;
      seg_wdata.p2 = tri_q.p2;
    end
    else
    begin
      seg_wdata.p0 = tri_q.p0;      // Left half
      seg_wdata.p1 = m0_q;
      seg_wdata.p2 = m2_q;
    end
  end

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
      state <= euclid_pkg::SD_IDLE;
    else
    begin
      case (state)
        euclid_pkg::SD_IDLE:
        begin
          if (subdiv_start)
            state <= euclid_pkg::SD_FETCH;
        end
        euclid_pkg::SD_FETCH:
          state <= seg_empty ? euclid_pkg::SD_IDLE : euclid_pkg::SD_MID;
        euclid_pkg::SD_MID:
          state <= is_leaf_c ? euclid_pkg::SD_LEAF : euclid_pkg::SD_PUSH0;
        euclid_pkg::SD_PUSH0:
          state <= euclid_pkg::SD_PUSH1;
        euclid_pkg::SD_PUSH1:
          state <= euclid_pkg::SD_FETCH;
        euclid_pkg::SD_LEAF:
        begin
          if (leaf_ack)
            state <= euclid_pkg::SD_FETCH;
        end
        default: state <= euclid_pkg::SD_IDLE;
      endcase
    end
  end

  always_ff @(posedge cr_intf)
  begin
    if (seg_pop)
    begin
      tri_q <= seg_rdata;
      m0_q  <= mid_pt(seg_rdata.p0, seg_rdata.p1);
      m1_q  <= mid_pt(seg_rdata.p1, seg_rdata.p2);
    end
    if (state == euclid_pkg::SD_MID)
      m2_q <= mid_pt(m0_q, m1_q);   // Point on the curve
  end

endmodule

`default_nettype wire

// ==== verilog/line_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_engine
(
  input  wire logic                  cr_intf,
  input  wire logic                  rst_n,
  input  wire logic                  line_start,
  input  wire euclid_pkg::line_req_t line_req,
  input  wire euclid_pkg::color_t    color,
  input  wire logic                  pxl_ready,
  output logic                       pxl_valid,
  output euclid_pkg::pxl_wr_t        pxl,
  output logic                       line_busy,
  output logic                       line_done
);

  euclid_pkg::line_state_e state;
  euclid_pkg::line_req_t   req_q;

  logic                                 sx_q;     // 1 steps x up
  logic                                 sy_q;
  logic [euclid_pkg::IDX_W-1:0]         dx_q;
  logic [euclid_pkg::IDX_W-1:0]         dy_q;
  logic signed [euclid_pkg::IDX_W:0]    err_q;

  logic                                 sx_c;
  logic                                 sy_c;
  logic [euclid_pkg::X_W-1:0]           adx_c;
  logic [euclid_pkg::Y_W-1:0]           ady_c;
  logic [euclid_pkg::IDX_W-1:0]         dx_c;
  logic [euclid_pkg::IDX_W-1:0]         dy_c;
  logic signed [euclid_pkg::IDX_W+1:0]  dx_s;
  logic signed [euclid_pkg::IDX_W+1:0]  dy_s;
  logic signed [euclid_pkg::IDX_W+1:0]  e2_c;
  logic signed [euclid_pkg::IDX_W+1:0]  err_nx_c;
  logic                                 step_x_c;
  logic                                 step_y_c;
  logic                                 accept_c;
  logic                                 at_end_c;

  // Setup terms from the latched endpoints
  assign sx_c  = (req_q.p1.x >= req_q.p0.x);
  assign sy_c  = (req_q.p1.y >= req_q.p0.y);
  assign adx_c = sx_c ? (req_q.p1.x - req_q.p0.x) : (req_q.p0.x - req_q.p1.x);
  assign ady_c = sy_c ? (req_q.p1.y - req_q.p0.y) : (req_q.p0.y - req_q.p1.y);
  assign dx_c  = {{(euclid_pkg::IDX_W - euclid_pkg::X_W){1'b0}}, adx_c};
  assign dy_c  = {{(euclid_pkg::IDX_W - euclid_pkg::Y_W){1'b0}}, ady_c};

  // Stepping decision
  assign dx_s     = $signed({2'b00, dx_q});
  assign dy_s     = $signed({2'b00, dy_q});
  assign e2_c     = $signed({err_q, 1'b0});
  assign step_x_c = (e2_c > -dy_s);
  assign step_y_c = (e2_c < dx_s);
  assign err_nx_c = $signed({err_q[euclid_pkg::IDX_W], err_q})
                    - (step_x_c ? dy_s : '0)
                    + (step_y_c ? dx_s : '0);

  assign accept_c  = pxl_valid & pxl_ready;
  assign at_end_c  = (pxl.pos == req_q.p1);
  assign line_done = accept_c & at_end_c;   // p1 taken by the gateway
  assign line_busy = (state != euclid_pkg::LN_IDLE);

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= euclid_pkg::LN_IDLE;
      pxl_valid <= 1'b0;
    end
    else
    begin
      case (state)
        euclid_pkg::LN_IDLE:
        begin
          if (line_start)
            state <= euclid_pkg::LN_SETUP;
        end
        euclid_pkg::LN_SETUP:
        begin
          pxl_valid <= 1'b1;            // First pixel is p0
          state     <= euclid_pkg::LN_DRAW;
        end
        euclid_pkg::LN_DRAW:
        begin
          if (line_done)
          begin
            pxl_valid <= 1'b0;
            state     <= euclid_pkg::LN_IDLE;
          end
        end
        default: state <= euclid_pkg::LN_IDLE;
      endcase
    end
  end

  always_ff @(posedge cr_intf)
  begin
    if ((state == euclid_pkg::LN_IDLE) && line_start)
      req_q <= line_req;

    if (state == euclid_pkg::LN_SETUP)
    begin
      sx_q      <= sx_c;
      sy_q      <= sy_c;
      dx_q      <= dx_c;
      dy_q      <= dy_c;
      err_q     <= $signed({1'b0, dx_c}) - $signed({1'b0, dy_c});   // dx - dy
      pxl.pos   <= req_q.p0;
      pxl.color <= color;
    end
    else if ((state == euclid_pkg::LN_DRAW) && accept_c)
    begin
      err_q <= err_nx_c[euclid_pkg::IDX_W:0];
      if (step_x_c)
        pxl.pos.x <= sx_q ? pxl.pos.x + 1'b1 : pxl.pos.x - 1'b1;
      if (step_y_c)
        pxl.pos.y <= sy_q ? pxl.pos.y + 1'b1 : pxl.pos.y - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/seg_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_fifo
(
  input  wire logic                             cr_intf,
  input  wire logic                             rst_n,
  input  wire logic                             push,
  input  wire euclid_pkg::seg_t                 wdata,
  input  wire logic                             pop,
  output euclid_pkg::seg_t                      rdata,
  output logic                                  empty,
  output logic [euclid_pkg::SEG_OCC_W-1:0]      occ
);

  euclid_pkg::seg_t mem [euclid_pkg::SEG_FIFO_DEPTH];

  // Pointers wrap on their own width
  logic [euclid_pkg::SEG_OCC_W-2:0] wr_ptr;
  logic [euclid_pkg::SEG_OCC_W-2:0] rd_ptr;

  assign empty = (occ == '0);
  assign rdata = mem[rd_ptr];       // Head shown without a read request

  always_ff @(posedge cr_intf)
  begin
    if (push)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;         // Idle or both at once
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/euclid_pkg.sv ====
`default_nettype none

package euclid_pkg;

  // Screen coordinate widths
  localparam int X_W     = 8;
  localparam int Y_W     = 8;
  localparam int IDX_W   = (X_W > Y_W) ? X_W + 1 : Y_W + 1;  // Delta and error width
  localparam int DEPTH_W = 3;

  localparam logic [DEPTH_W-1:0] MAX_BZ_DEPTH = DEPTH_W'(3);

  // Breadth-first needs room for every triangle of the deepest level
  localparam int SEG_FIFO_DEPTH = 16;
  localparam int SEG_OCC_W      = 5;

  typedef logic [15:0] color_t;

  typedef struct packed {
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
  } point_t;

  typedef enum logic {
    LINE,
    BEZIER
  } shape_e;

  typedef struct packed {
    shape_e             shape;
    point_t             p0;
    point_t             p1;
    point_t             p2;     // Bezier only
    color_t             color;
    logic [DEPTH_W-1:0] bzdepth;
  } euclid_job_t;

  // One triangle in the subdivision queue
  typedef struct packed {
    point_t             p0;
    point_t             p1;
    point_t             p2;
    logic [DEPTH_W-1:0] depth;
  } seg_t;

  typedef struct packed {
    point_t p0;
    point_t p1;
  } line_req_t;

  typedef struct packed {
    point_t pos;
    color_t color;
  } pxl_wr_t;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_START,
    CS_LINE_RUN,
    CS_BZ_RUN,
    CS_LEAF0,
    CS_LEAF1
  } ctrl_state_e;

  typedef enum logic [2:0] {
    SD_IDLE,
    SD_FETCH,
    SD_MID,
    SD_PUSH0,
    SD_PUSH1,
    SD_LEAF
  } subdiv_state_e;

  typedef enum logic [1:0] {
    LN_IDLE,
    LN_SETUP,
    LN_DRAW
  } line_state_e;

endpackage

`default_nettype wire
